// ==== pinmux_cfg_pkg.sv ====
package pinmux_cfg_pkg;

  // --------------------------------------------------
  // Register bus geometry
  // --------------------------------------------------
  localparam int REG_AW = 8;
  localparam int REG_DW = 32;

  // Byte addresses, word aligned
  localparam logic [REG_AW-1:0] ADDR_GPIO_DIR      = 8'h00;
  localparam logic [REG_AW-1:0] ADDR_GPIO_OUT      = 8'h04;
  // Read only, synchronized pad level
  localparam logic [REG_AW-1:0] ADDR_GPIO_IN       = 8'h08;
  localparam logic [REG_AW-1:0] ADDR_GPIO_POS_SEL  = 8'h0C;
  localparam logic [REG_AW-1:0] ADDR_GPIO_NEG_SEL  = 8'h10;
  // Write one to clear
  localparam logic [REG_AW-1:0] ADDR_GPIO_INT_STAT = 8'h14;
  localparam logic [REG_AW-1:0] ADDR_GPIO_INT_MASK = 8'h18;
  localparam logic [REG_AW-1:0] ADDR_MULTI_FUNC    = 8'h1C;
  localparam logic [REG_AW-1:0] ADDR_PULSE_1US     = 8'h20;
  // PWM n at base + 4n
  localparam logic [REG_AW-1:0] ADDR_PWM_BASE      = 8'h24;

  // Implemented MULTI_FUNC bits, rest stored as zero
  localparam logic [REG_DW-1:0] MF_USED_MASK = 32'h0000_01FF;

  // --------------------------------------------------
  // Feature sizes
  // --------------------------------------------------
  // Port A 7..0, B 15..8, C 23..16, D 31..24
  localparam int GPIO_W    = 32;
  localparam int NUM_PWM   = 6;
  localparam int PWM_CNT_W = 16;
  localparam int PULSE_W   = 10;

  typedef struct packed {
    logic                cs;
    logic                wr;
    logic [REG_AW-1:0]   addr;
    logic [REG_DW-1:0]   wdata;
    logic [REG_DW/8-1:0] be;
  } reg_req_t;

  typedef struct packed {
    logic [REG_DW-1:0] rdata;
    logic              ack;
  } reg_rsp_t;

  // Raw word for readback, field view for decode
  typedef union packed {
    logic [REG_DW-1:0] word;
    struct packed {
      logic [22:0]        rsvd;
      logic               uart_enb;
      logic [1:0]         int_enb;
      logic [NUM_PWM-1:0] pwm_enb;
    } fld;
  } multi_func_u;

  // Low count in the upper half word
  typedef struct packed {
    logic [PWM_CNT_W-1:0] lo_cnt;
    logic [PWM_CNT_W-1:0] hi_cnt;
  } pwm_cfg_t;

  typedef struct packed {
    logic [GPIO_W-1:0]      gpio_dir;
    logic [GPIO_W-1:0]      gpio_out;
    logic [GPIO_W-1:0]      pos_sel;
    logic [GPIO_W-1:0]      neg_sel;
    logic [GPIO_W-1:0]      int_mask;
    multi_func_u            multi_func;
    logic [PULSE_W-1:0]     pulse_1us;
    pwm_cfg_t [NUM_PWM-1:0] pwm;
  } pinmux_cfg_t;

endpackage

// ==== pinmux_pad_pkg.sv ====
package pinmux_pad_pkg;

  import pinmux_cfg_pkg::*;

  localparam int NUM_PADS = 24;
  // Marks a GPIO bit without a pad
  localparam int PAD_NONE = -1;

  // Alternate function pads, 28-pin layout
  localparam int PAD_RXD  = 1;
  localparam int PAD_TXD  = 2;
  localparam int PAD_INT0 = 3;
  localparam int PAD_INT1 = 4;
  localparam int PAD_PWM0 = 4;
  localparam int PAD_PWM1 = 8;
  localparam int PAD_PWM2 = 9;
  localparam int PAD_PWM3 = 12;
  localparam int PAD_PWM4 = 13;
  localparam int PAD_PWM5 = 14;

  // --------------------------------------------------
  // Pad of each GPIO bit, index is the GPIO bit
  // --------------------------------------------------
  localparam int GPIO_PAD_MAP [GPIO_W] = '{
    // Port A, no pads
    PAD_NONE, PAD_NONE, PAD_NONE, PAD_NONE,
    PAD_NONE, PAD_NONE, PAD_NONE, PAD_NONE,
    // Port B, B6/B7 on the crystal pins
    11, 12, 13, 14, 15, 16, 6, 7,
    // Port C, C6 on the reset pin, C7 not bonded
    18, 19, 20, 21, 22, 23, 0, PAD_NONE,
    // Port D
    1, 2, 3, 4, 5, 8, 9, 10
  };

  typedef struct packed {
    logic       uart_rxd;
    logic [1:0] ext_intr;
  } periph_in_t;

  typedef struct packed {
    logic               uart_txd;
    logic [NUM_PWM-1:0] pwm;
  } periph_out_t;

endpackage

// ==== pinmux_reg.sv ====
`timescale 1ns/1ps

module pinmux_reg import pinmux_cfg_pkg::*; (
  input  logic              mclk,
  input  logic              rst_n_i,
  // Register bus
  input  reg_req_t          reg_req_i,
  output reg_rsp_t          reg_rsp_o,
  // Readback sources
  input  logic [GPIO_W-1:0] gpio_in_i,
  input  logic [GPIO_W-1:0] int_stat_i,
  // Configuration towards the datapath
  output pinmux_cfg_t       cfg_o,
  output logic [GPIO_W-1:0] int_clr_o
);

  pinmux_cfg_t       cfg_q;
  reg_rsp_t          rsp_q;
  logic              acc_start;
  logic              wr_en;
  logic [REG_DW-1:0] wmask;
  logic [REG_DW-1:0] rdata_nxt;

  // Byte lane merge of write data into old value
  function automatic logic [REG_DW-1:0] merge(input logic [REG_DW-1:0] old_val,
                                              input logic [REG_DW-1:0] new_val,
                                              input logic [REG_DW-1:0] mask);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic logic [REG_AW-1:0] pwm_addr(input int n);
    return ADDR_PWM_BASE + REG_AW'(4 * n);
  endfunction

  // Byte enables widened to a bit mask
  always_comb begin
    for (int b = 0; b < REG_DW/8; b++) begin
      wmask[8*b +: 8] = {8{reg_req_i.be[b]}};
    end
  end

  // New access only while ack is low
  assign acc_start = reg_req_i.cs & ~rsp_q.ack;
  assign wr_en     = acc_start & reg_req_i.wr;

  // --------------------------------------------------
  // Configuration write
  // --------------------------------------------------
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.addr)
        ADDR_GPIO_DIR:
          cfg_q.gpio_dir <= merge(cfg_q.gpio_dir, reg_req_i.wdata, wmask);
        ADDR_GPIO_OUT:
          cfg_q.gpio_out <= merge(cfg_q.gpio_out, reg_req_i.wdata, wmask);
        ADDR_GPIO_POS_SEL:
          cfg_q.pos_sel <= merge(cfg_q.pos_sel, reg_req_i.wdata, wmask);
        ADDR_GPIO_NEG_SEL:
          cfg_q.neg_sel <= merge(cfg_q.neg_sel, reg_req_i.wdata, wmask);
        ADDR_GPIO_INT_MASK:
          cfg_q.int_mask <= merge(cfg_q.int_mask, reg_req_i.wdata, wmask);
        ADDR_MULTI_FUNC:
          // Reserved bits never stored
          cfg_q.multi_func.word <= merge(cfg_q.multi_func.word, reg_req_i.wdata, wmask)
                                   & MF_USED_MASK;
        ADDR_PULSE_1US: begin
          // 10-bit count spans two byte lanes
          if (reg_req_i.be[0]) cfg_q.pulse_1us[7:0] <= reg_req_i.wdata[7:0];
          if (reg_req_i.be[1]) cfg_q.pulse_1us[9:8] <= reg_req_i.wdata[9:8];
        end
        default: begin
          for (int n = 0; n < NUM_PWM; n++) begin
            if (reg_req_i.addr == pwm_addr(n)) begin
              cfg_q.pwm[n] <= merge(cfg_q.pwm[n], reg_req_i.wdata, wmask);
            end
          end
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Read mux, unused addresses give zero
  // --------------------------------------------------
  always_comb begin
    rdata_nxt = '0;
    case (reg_req_i.addr)
      ADDR_GPIO_DIR:      rdata_nxt = cfg_q.gpio_dir;
      ADDR_GPIO_OUT:      rdata_nxt = cfg_q.gpio_out;
      ADDR_GPIO_IN:       rdata_nxt = gpio_in_i;
      ADDR_GPIO_POS_SEL:  rdata_nxt = cfg_q.pos_sel;
      ADDR_GPIO_NEG_SEL:  rdata_nxt = cfg_q.neg_sel;
      ADDR_GPIO_INT_STAT: rdata_nxt = int_stat_i;
      ADDR_GPIO_INT_MASK: rdata_nxt = cfg_q.int_mask;
      ADDR_MULTI_FUNC:    rdata_nxt = cfg_q.multi_func.word;
      ADDR_PULSE_1US:     rdata_nxt = REG_DW'(cfg_q.pulse_1us);
      default: begin
        for (int n = 0; n < NUM_PWM; n++) begin
          if (reg_req_i.addr == pwm_addr(n)) begin
            rdata_nxt = cfg_q.pwm[n];
          end
        end
      end
    endcase
  end

  // Single cycle ack, read data captured alongside
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_q <= '0;
    end else begin
      rsp_q.ack <= acc_start;
      if (acc_start) begin
        rsp_q.rdata <= rdata_nxt;
      end
    end
  end

  // Clear strobe lands on the ack edge
  assign int_clr_o = (wr_en && reg_req_i.addr == ADDR_GPIO_INT_STAT) ?
                     (reg_req_i.wdata & wmask) : '0;

  assign reg_rsp_o = rsp_q;
  assign cfg_o     = cfg_q;

endmodule

// ==== gpio_intr.sv ====
`timescale 1ns/1ps

module gpio_intr import pinmux_cfg_pkg::*; (
  input  logic              mclk,
  input  logic              rst_n_i,
  // Synchronized GPIO level
  input  logic [GPIO_W-1:0] gpio_in_i,
  // Edge select, mask and clear strobe
  input  logic [GPIO_W-1:0] pos_sel_i,
  input  logic [GPIO_W-1:0] neg_sel_i,
  input  logic [GPIO_W-1:0] int_mask_i,
  input  logic [GPIO_W-1:0] int_clr_i,
  output logic [GPIO_W-1:0] int_stat_o,
  output logic              gpio_irq_o
);

  logic [GPIO_W-1:0] prev_q;
  logic [GPIO_W-1:0] stat_q;
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] fall;
  logic [GPIO_W-1:0] set;

  // Edges against last sampled level
  assign rise = gpio_in_i & ~prev_q;
  assign fall = ~gpio_in_i & prev_q;
  assign set  = (rise & pos_sel_i) | (fall & neg_sel_i);

  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prev_q <= '0;
      stat_q <= '0;
    end else begin
      prev_q <= gpio_in_i;
      // Sticky, new event beats clear
      stat_q <= (stat_q & ~int_clr_i) | set;
    end
  end

  assign int_stat_o = stat_q;
  // Any enabled pending bit
  assign gpio_irq_o = |(stat_q & int_mask_i);

endmodule

// ==== pulse_tick_gen.sv ====
`timescale 1ns/1ps

module pulse_tick_gen import pinmux_cfg_pkg::*; #(
  parameter int MS_DIV = 1000
) (
  input  logic               mclk,
  input  logic               rst_n_i,
  // Cycles per 1 us minus one
  input  logic [PULSE_W-1:0] cfg_1us_i,
  output logic               tick_1us_o,
  output logic               tick_1ms_o
);

  localparam int MS_W = (MS_DIV > 1) ? $clog2(MS_DIV) : 1;

  logic [PULSE_W-1:0] us_cnt_q;
  logic [PULSE_W-1:0] cfg_q;
  logic [MS_W-1:0]    ms_cnt_q;
  logic               us_hit;

  assign us_hit = (us_cnt_q >= cfg_1us_i);

  // --------------------------------------------------
  // 1 us tick, period cfg + 1 cycles
  // --------------------------------------------------
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      us_cnt_q   <= '0;
      cfg_q      <= '0;
      tick_1us_o <= 1'b0;
    end else begin
      cfg_q      <= cfg_1us_i;
      tick_1us_o <= 1'b0;
      // Restart count on a new setting
      if (cfg_1us_i != cfg_q) begin
        us_cnt_q <= '0;
      end else if (us_hit) begin
        us_cnt_q   <= '0;
        tick_1us_o <= 1'b1;
      end else begin
        us_cnt_q <= us_cnt_q + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // 1 ms tick, every MS_DIV us ticks
  // --------------------------------------------------
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ms_cnt_q   <= '0;
      tick_1ms_o <= 1'b0;
    end else begin
      tick_1ms_o <= 1'b0;
      if (tick_1us_o) begin
        if (ms_cnt_q == MS_W'(MS_DIV - 1)) begin
          ms_cnt_q   <= '0;
          tick_1ms_o <= 1'b1;
        end else begin
          ms_cnt_q <= ms_cnt_q + 1'b1;
        end
      end
    end
  end

endmodule

// ==== pwm_gen.sv ====
`timescale 1ns/1ps

module pwm_gen import pinmux_cfg_pkg::*; (
  input  logic     mclk,
  input  logic     rst_n_i,
  input  logic     tick_1ms_i,
  input  logic     enb_i,
  // High and low phase lengths in ms
  input  pwm_cfg_t cfg_i,
  output logic     wfm_o
);

  logic                 hi_q;
  logic [PWM_CNT_W-1:0] cnt_q;
  logic [PWM_CNT_W-1:0] lim;

  // Length of the current phase, zero acts as one
  always_comb begin
    lim = hi_q ? cfg_i.hi_cnt : cfg_i.lo_cnt;
    if (lim == '0) begin
      lim = PWM_CNT_W'(1);
    end
  end

  // --------------------------------------------------
  // Phase counter
  // --------------------------------------------------
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hi_q  <= 1'b1;
      cnt_q <= '0;
    end else if (!enb_i) begin
      // Parked at the start of a high phase
      hi_q  <= 1'b1;
      cnt_q <= '0;
    end else if (tick_1ms_i) begin
      if (cnt_q >= lim - PWM_CNT_W'(1)) begin
        hi_q  <= ~hi_q;
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Low whenever the channel is off
  assign wfm_o = enb_i & hi_q;

endmodule

// ==== pad_in_demux.sv ====
`timescale 1ns/1ps

module pad_in_demux import pinmux_cfg_pkg::*, pinmux_pad_pkg::*; (
  input  logic                mclk,
  input  logic                rst_n_i,
  // Raw pad levels
  input  logic [NUM_PADS-1:0] pad_in_i,
  input  multi_func_u         mfunc_i,
  output logic [GPIO_W-1:0]   gpio_in_o,
  output periph_in_t          periph_o
);

  logic [NUM_PADS-1:0] meta_q;
  logic [NUM_PADS-1:0] sync_q;

  // Two flop synchronizer on every pad
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= pad_in_i;
      sync_q <= meta_q;
    end
  end

  // --------------------------------------------------
  // GPIO word, unmapped bits read zero
  // --------------------------------------------------
  for (genvar g = 0; g < GPIO_W; g++) begin : g_gpio
    if (GPIO_PAD_MAP[g] == PAD_NONE) begin : g_nc
      assign gpio_in_o[g] = 1'b0;
    end else begin : g_pad
      assign gpio_in_o[g] = sync_q[GPIO_PAD_MAP[g]];
    end
  end

  // Peripheral inputs only when the function is on
  assign periph_o.uart_rxd    = mfunc_i.fld.uart_enb & sync_q[PAD_RXD];
  assign periph_o.ext_intr[0] = mfunc_i.fld.int_enb[0] & sync_q[PAD_INT0];
  assign periph_o.ext_intr[1] = mfunc_i.fld.int_enb[1] & sync_q[PAD_INT1];

endmodule

// ==== pad_out_mux.sv ====
`timescale 1ns/1ps

module pad_out_mux import pinmux_cfg_pkg::*, pinmux_pad_pkg::*; (
  input  pinmux_cfg_t         cfg_i,
  input  periph_out_t         periph_i,
  output logic [NUM_PADS-1:0] pad_out_o,
  // Active low output enable
  output logic [NUM_PADS-1:0] pad_oen_o
);

  localparam int PWM_PAD [NUM_PWM] = '{
    PAD_PWM0, PAD_PWM1, PAD_PWM2, PAD_PWM3, PAD_PWM4, PAD_PWM5
  };

  logic [NUM_PADS-1:0] gpio_drv;
  logic [NUM_PADS-1:0] gpio_val;

  // Reverse lookup of the GPIO map, -1 if none
  function automatic int gpio_bit_of(input int pad);
    int gbit;
    gbit = -1;
    for (int g = 0; g < GPIO_W; g++) begin
      if (GPIO_PAD_MAP[g] == pad) begin
        gbit = g;
      end
    end
    return gbit;
  endfunction

  // --------------------------------------------------
  // GPIO drive per pad
  // --------------------------------------------------
  for (genvar p = 0; p < NUM_PADS; p++) begin : g_pad
    localparam int GB = gpio_bit_of(p);
    if (GB >= 0) begin : g_gpio
      assign gpio_drv[p] = cfg_i.gpio_dir[GB];
      assign gpio_val[p] = cfg_i.gpio_out[GB];
    end else begin : g_nc
      // pad 17 has no function here
      assign gpio_drv[p] = 1'b0;
      assign gpio_val[p] = 1'b0;
    end
  end

  // --------------------------------------------------
  // Priority, later assignments win
  // --------------------------------------------------
  always_comb begin
    // GPIO first, idle pads float low
    pad_out_o = gpio_drv & gpio_val;
    pad_oen_o = ~gpio_drv;

    // External interrupts turn pads to inputs
    if (cfg_i.multi_func.fld.int_enb[0]) begin
      pad_out_o[PAD_INT0] = 1'b0;
      pad_oen_o[PAD_INT0] = 1'b1;
    end
    if (cfg_i.multi_func.fld.int_enb[1]) begin
      pad_out_o[PAD_INT1] = 1'b0;
      pad_oen_o[PAD_INT1] = 1'b1;
    end

    // UART, TXD driven and RXD input
    if (cfg_i.multi_func.fld.uart_enb) begin
      pad_out_o[PAD_TXD] = periph_i.uart_txd;
      pad_oen_o[PAD_TXD] = 1'b0;
      pad_out_o[PAD_RXD] = 1'b0;
      pad_oen_o[PAD_RXD] = 1'b1;
    end

    // PWM on top, PWM0 also beats INT1
    for (int n = 0; n < NUM_PWM; n++) begin
      if (cfg_i.multi_func.fld.pwm_enb[n]) begin
        pad_out_o[PWM_PAD[n]] = periph_i.pwm[n];
        pad_oen_o[PWM_PAD[n]] = 1'b0;
      end
    end
  end

endmodule

// ==== pinmux_top.sv ====
`timescale 1ns/1ps

module pinmux_top import pinmux_cfg_pkg::*, pinmux_pad_pkg::*; #(
  // us ticks per ms tick
  parameter int MS_DIV = 1000
) (
  input  logic                mclk,
  input  logic                rst_n_i,
  // Register bus
  input  reg_req_t            reg_req_i,
  output reg_rsp_t            reg_rsp_o,
  // Pads
  input  logic [NUM_PADS-1:0] digital_io_in_i,
  output logic [NUM_PADS-1:0] digital_io_out_o,
  output logic [NUM_PADS-1:0] digital_io_oen_o,
  // Peripheral side
  input  logic                uart_txd_i,
  output logic                uart_rxd_o,
  output logic [1:0]          ext_irq_o,
  output logic                gpio_irq_o
);

  pinmux_cfg_t       cfg;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] int_stat;
  logic [GPIO_W-1:0] int_clr;
  logic              tick_1ms;
  periph_in_t        periph_in;
  periph_out_t       periph_out;

  // --------------------------------------------------
  // Input side
  // --------------------------------------------------
  pad_in_demux u_pad_in_demux (
    .mclk      (mclk),
    .rst_n_i   (rst_n_i),
    .pad_in_i  (digital_io_in_i),
    .mfunc_i   (cfg.multi_func),
    .gpio_in_o (gpio_in),
    .periph_o  (periph_in)
  );

  assign uart_rxd_o = periph_in.uart_rxd;
  assign ext_irq_o  = periph_in.ext_intr;

  pinmux_reg u_pinmux_reg (
    .mclk       (mclk),
    .rst_n_i    (rst_n_i),
    .reg_req_i  (reg_req_i),
    .reg_rsp_o  (reg_rsp_o),
    .gpio_in_i  (gpio_in),
    .int_stat_i (int_stat),
    .cfg_o      (cfg),
    .int_clr_o  (int_clr)
  );

  gpio_intr u_gpio_intr (
    .mclk       (mclk),
    .rst_n_i    (rst_n_i),
    .gpio_in_i  (gpio_in),
    .pos_sel_i  (cfg.pos_sel),
    .neg_sel_i  (cfg.neg_sel),
    .int_mask_i (cfg.int_mask),
    .int_clr_i  (int_clr),
    .int_stat_o (int_stat),
    .gpio_irq_o (gpio_irq_o)
  );

  // --------------------------------------------------
  // Timebase and PWM
  // --------------------------------------------------
  pulse_tick_gen #(
    .MS_DIV (MS_DIV)
  ) u_pulse_tick_gen (
    .mclk       (mclk),
    .rst_n_i    (rst_n_i),
    .cfg_1us_i  (cfg.pulse_1us),
    // only the ms tick leaves this block
    .tick_1us_o (),
    .tick_1ms_o (tick_1ms)
  );

  for (genvar n = 0; n < NUM_PWM; n++) begin : g_pwm
    pwm_gen u_pwm_gen (
      .mclk       (mclk),
      .rst_n_i    (rst_n_i),
      .tick_1ms_i (tick_1ms),
      .enb_i      (cfg.multi_func.fld.pwm_enb[n]),
      .cfg_i      (cfg.pwm[n]),
      .wfm_o      (periph_out.pwm[n])
    );
  end

  assign periph_out.uart_txd = uart_txd_i;

  // Output side
  pad_out_mux u_pad_out_mux (
    .cfg_i     (cfg),
    .periph_i  (periph_out),
    .pad_out_o (digital_io_out_o),
    .pad_oen_o (digital_io_oen_o)
  );

endmodule

// ==== tb_pinmux.sv ====
`timescale 1ns/1ps

module tb_pinmux import pinmux_cfg_pkg::*, pinmux_pad_pkg::*;;

  // Step kinds
  localparam logic [1:0] OP_WR  = 2'd0;
  localparam logic [1:0] OP_RD  = 2'd1;
  localparam logic [1:0] OP_CHK = 2'd2;
  // Pad drive patterns and GPIO status bits
  localparam logic [23:0] NO_PADS = 24'h000000;
  localparam logic [23:0] P1 = 24'h000002;
  localparam logic [23:0] P3 = 24'h000008;
  localparam logic [23:0] P4 = 24'h000010;
  localparam logic [23:0] P8 = 24'h000100;
  localparam logic [31:0] B26 = 32'h0400_0000;
  localparam logic [31:0] B29 = 32'h2000_0000;
  localparam int PWM_TEST_CYC = 300;

  typedef struct packed {
    logic [1:0]  op;
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [23:0] pads;
    logic [31:0] exp;
  } step_t;

  logic        mclk;
  logic        rst_n_i;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp_o;
  logic [23:0] digital_io_in_i;
  logic [23:0] digital_io_out_o;
  logic [23:0] digital_io_oen_o;
  logic        uart_txd_i;
  logic        uart_rxd_o;
  logic [1:0]  ext_irq_o;
  logic        gpio_irq_o;

  step_t       steps[$];
  logic        table_ready = 1'b0;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] rng_state = 32'd67233;
  // Shadow of the configuration that shapes the pads
  logic [31:0] sh_dir = '0;
  logic [31:0] sh_out = '0;
  logic [31:0] sh_mf  = '0;

  pinmux_top #(.MS_DIV(4)) uut (
    .mclk             (mclk),
    .rst_n_i          (rst_n_i),
    .reg_req_i        (reg_req),
    .reg_rsp_o        (reg_rsp_o),
    .digital_io_in_i  (digital_io_in_i),
    .digital_io_out_o (digital_io_out_o),
    .digital_io_oen_o (digital_io_oen_o),
    .uart_txd_i       (uart_txd_i),
    .uart_rxd_o       (uart_rxd_o),
    .ext_irq_o        (ext_irq_o),
    .gpio_irq_o       (gpio_irq_o)
  );

  initial mclk = 1'b0;
  always #5 mclk = ~mclk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] byte_mask(input logic [3:0] be);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  // Expected GPIO_IN word for a pad pattern
  function automatic logic [31:0] gpio_in_of(input logic [23:0] pads);
    logic [31:0] v;
    v = '0;
    for (int g = 0; g < GPIO_W; g++) begin
      if (GPIO_PAD_MAP[g] != PAD_NONE) begin
        v[g] = pads[GPIO_PAD_MAP[g]];
      end
    end
    return v;
  endfunction

  // Pad out in the upper half and oen in the lower half
  function automatic logic [47:0] pad_model(input logic txd);
    logic [23:0] o;
    logic [23:0] e;
    o = '0;
    e = '1;
    for (int g = 0; g < GPIO_W; g++) begin
      if (GPIO_PAD_MAP[g] != PAD_NONE && sh_dir[g]) begin
        o[GPIO_PAD_MAP[g]] = sh_out[g];
        e[GPIO_PAD_MAP[g]] = 1'b0;
      end
    end
    // Interrupt pads as inputs
    if (sh_mf[6]) begin
      o[PAD_INT0] = 1'b0;
      e[PAD_INT0] = 1'b1;
    end
    if (sh_mf[7]) begin
      o[PAD_INT1] = 1'b0;
      e[PAD_INT1] = 1'b1;
    end
    if (sh_mf[8]) begin
      o[PAD_TXD] = txd;
      e[PAD_TXD] = 1'b0;
      o[PAD_RXD] = 1'b0;
      e[PAD_RXD] = 1'b1;
    end
    // Table PWMs sit in a long high phase
    if (sh_mf[0]) begin
      o[PAD_PWM0] = 1'b1;
      e[PAD_PWM0] = 1'b0;
    end
    if (sh_mf[1]) begin
      o[PAD_PWM1] = 1'b1;
      e[PAD_PWM1] = 1'b0;
    end
    if (sh_mf[3]) begin
      o[PAD_PWM3] = 1'b1;
      e[PAD_PWM3] = 1'b0;
    end
    return {o, e};
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
    end
  endtask

  task automatic add_step(input logic [1:0] op, input logic [7:0] addr,
                          input logic [31:0] wdata, input logic [3:0] be,
                          input logic [23:0] pads, input logic [31:0] exp);
    step_t s;
    s = {op, addr, wdata, be, pads, exp};
    steps.push_back(s);
  endtask

  // Called at rising edge plus 1 ns and returns one cycle after ack
  task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata);
    int wait_cyc;
    rdata = '0;
    wait_cyc = 0;
    reg_req.cs    = 1'b1;
    reg_req.wr    = wr;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    reg_req.be    = be;
    @(posedge mclk);
    #1;
    while (!reg_rsp_o.ack && wait_cyc < 16) begin
      @(posedge mclk);
      #1;
      wait_cyc++;
    end
    if (reg_rsp_o.ack) begin
      rdata = reg_rsp_o.rdata;
    end else begin
      errors++;
      $display("Access to address %h got no acknowledge within 16 cycles", addr);
    end
    reg_req = '0;
    @(posedge mclk);
    #1;
    if (reg_rsp_o.ack) begin
      errors++;
      $display("Acknowledge at %0t ns lasted longer than one cycle", $time);
    end
  endtask

  task automatic apply_step(input step_t s);
    logic [31:0] rd;
    logic [31:0] m;
    logic [47:0] pm;
    digital_io_in_i = s.pads;
    if (s.op == OP_CHK) begin
      uart_txd_i = s.wdata[0];
    end
    // Let pad levels cross the synchronizer and edge logic
    repeat (4) @(posedge mclk);
    #1;
    case (s.op)
      OP_WR: begin
        bus_access(1'b1, s.addr, s.wdata, s.be, rd);
        m = byte_mask(s.be);
        if (s.addr == ADDR_GPIO_DIR) sh_dir = (sh_dir & ~m) | (s.wdata & m);
        if (s.addr == ADDR_GPIO_OUT) sh_out = (sh_out & ~m) | (s.wdata & m);
        // Only bits 8..0 of MULTI_FUNC exist
        if (s.addr == ADDR_MULTI_FUNC) sh_mf = ((sh_mf & ~m) | (s.wdata & m)) & 32'h1FF;
      end
      OP_RD: begin
        bus_access(1'b0, s.addr, 32'h0, 4'h0, rd);
        check_val($sformatf("rdata[%h]", s.addr), s.exp, rd);
      end
      default: begin
        pm = pad_model(s.wdata[0]);
        check_val("digital_io_out_o", 32'(pm[47:24]), 32'(digital_io_out_o));
        check_val("digital_io_oen_o", 32'(pm[23:0]), 32'(digital_io_oen_o));
        check_val("uart_rxd_o", 32'(sh_mf[8] & s.pads[PAD_RXD]), 32'(uart_rxd_o));
        check_val("ext_irq_o", 32'({sh_mf[7] & s.pads[PAD_INT1], sh_mf[6] & s.pads[PAD_INT0]}),
                  32'(ext_irq_o));
        check_val("gpio_irq_o", 32'(s.exp[0]), 32'(gpio_irq_o));
      end
    endcase
  endtask

  // Cycles until PWM0 pad reaches a level
  task automatic wait_pwm0(input logic level, output int cyc);
    cyc = 0;
    while (digital_io_out_o[PAD_PWM0] !== level && cyc < 64) begin
      @(posedge mclk);
      #1;
      cyc++;
    end
    if (digital_io_out_o[PAD_PWM0] !== level) begin
      errors++;
      $display("PWM0 pad never reached level %b within 64 cycles", level);
    end
  endtask

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------
  task automatic build_table();
    logic [31:0] r;
    logic [31:0] q;
    logic [23:0] p;
    // Byte enable merge plus reserved and unused space
    add_step(OP_WR, ADDR_GPIO_POS_SEL, 32'h1122_3344, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_GPIO_POS_SEL, 32'hAABB_CCDD, 4'b0101, NO_PADS, 32'h0);
    add_step(OP_RD, ADDR_GPIO_POS_SEL, 32'h0, 4'h0, NO_PADS, 32'h11BB_33DD);
    add_step(OP_WR, ADDR_GPIO_POS_SEL, 32'h0, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_MULTI_FUNC, 32'hFFFF_FFFF, 4'b0010, NO_PADS, 32'h0);
    add_step(OP_RD, ADDR_MULTI_FUNC, 32'h0, 4'h0, NO_PADS, 32'h0000_0100);
    add_step(OP_WR, ADDR_MULTI_FUNC, 32'hFFFF_FE00, 4'hF, NO_PADS, 32'h0);
    add_step(OP_RD, ADDR_MULTI_FUNC, 32'h0, 4'h0, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_PULSE_1US, 32'hFFFF_FFFF, 4'hF, NO_PADS, 32'h0);
    add_step(OP_RD, ADDR_PULSE_1US, 32'h0, 4'h0, NO_PADS, 32'h0000_03FF);
    add_step(OP_WR, ADDR_PULSE_1US, 32'h0, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, 8'h38, 32'h1234_5678, 4'b1100, NO_PADS, 32'h0);
    add_step(OP_RD, 8'h38, 32'h0, 4'h0, NO_PADS, 32'h1234_0000);
    add_step(OP_WR, 8'h38, 32'h0, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, 8'h3C, 32'hFFFF_FFFF, 4'hF, NO_PADS, 32'h0);
    add_step(OP_RD, 8'h3C, 32'h0, 4'h0, NO_PADS, 32'h0);
    add_step(OP_RD, 8'hFC, 32'h0, 4'h0, NO_PADS, 32'h0);
    // Random GPIO output and input
    for (int i = 0; i < 3; i++) begin
      r = next_rand();
      q = next_rand();
      add_step(OP_WR, ADDR_GPIO_DIR, r, 4'hF, NO_PADS, 32'h0);
      add_step(OP_WR, ADDR_GPIO_OUT, q, 4'hF, NO_PADS, 32'h0);
      r = next_rand();
      p = r[23:0];
      add_step(OP_CHK, 8'h00, 32'h0, 4'h0, p, 32'h0);
      add_step(OP_RD, ADDR_GPIO_IN, 32'h0, 4'h0, p, gpio_in_of(p));
    end
    // Pad 3 rise selected and masked in while pad 8 fall is selected only
    add_step(OP_WR, ADDR_GPIO_DIR, 32'h0, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_GPIO_INT_STAT, 32'hFFFF_FFFF, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_GPIO_POS_SEL, B26, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_GPIO_NEG_SEL, B29, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_GPIO_INT_MASK, B26, 4'hF, NO_PADS, 32'h0);
    add_step(OP_RD, ADDR_GPIO_INT_STAT, 32'h0, 4'h0, NO_PADS, 32'h0);
    add_step(OP_CHK, 8'h00, 32'h0, 4'h0, P8, 32'h0);
    add_step(OP_RD, ADDR_GPIO_INT_STAT, 32'h0, 4'h0, P8, 32'h0);
    add_step(OP_CHK, 8'h00, 32'h0, 4'h0, NO_PADS, 32'h0);
    add_step(OP_RD, ADDR_GPIO_INT_STAT, 32'h0, 4'h0, NO_PADS, B29);
    add_step(OP_CHK, 8'h00, 32'h0, 4'h0, P3, 32'h1);
    add_step(OP_RD, ADDR_GPIO_INT_STAT, 32'h0, 4'h0, P3, B29 | B26);
    add_step(OP_WR, ADDR_GPIO_INT_STAT, B26, 4'hF, P3, 32'h0);
    add_step(OP_CHK, 8'h00, 32'h0, 4'h0, P3, 32'h0);
    add_step(OP_RD, ADDR_GPIO_INT_STAT, 32'h0, 4'h0, P3, B29);
    add_step(OP_WR, ADDR_GPIO_INT_STAT, B29, 4'hF, P3, 32'h0);
    add_step(OP_CHK, 8'h00, 32'h0, 4'h0, NO_PADS, 32'h0);
    add_step(OP_RD, ADDR_GPIO_INT_STAT, 32'h0, 4'h0, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_GPIO_POS_SEL, 32'h0, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_GPIO_NEG_SEL, 32'h0, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_GPIO_INT_MASK, 32'h0, 4'hF, NO_PADS, 32'h0);
    // Alternate functions over all-output GPIO
    r = next_rand();
    add_step(OP_WR, ADDR_GPIO_DIR, 32'hFFFF_FFFF, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_GPIO_OUT, r, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_MULTI_FUNC, 32'h0000_0100, 4'hF, NO_PADS, 32'h0);
    add_step(OP_CHK, 8'h00, 32'h1, 4'h0, P1, 32'h0);
    add_step(OP_CHK, 8'h00, 32'h0, 4'h0, NO_PADS, 32'h0);
    add_step(OP_CHK, 8'h00, 32'h1, 4'h0, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_MULTI_FUNC, 32'h0000_00C0, 4'hF, NO_PADS, 32'h0);
    add_step(OP_CHK, 8'h00, 32'h0, 4'h0, P3, 32'h0);
    add_step(OP_CHK, 8'h00, 32'h0, 4'h0, P4, 32'h0);
    add_step(OP_WR, ADDR_PWM_BASE, 32'h0001_FFFF, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_PWM_BASE + 8'd4, 32'h0001_FFFF, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_PWM_BASE + 8'd12, 32'h0001_FFFF, 4'hF, NO_PADS, 32'h0);
    // GPIO low under the PWM pads so the high PWM level stands out
    add_step(OP_WR, ADDR_GPIO_OUT, 32'h0, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_MULTI_FUNC, 32'h0000_01CB, 4'hF, NO_PADS, 32'h0);
    add_step(OP_CHK, 8'h00, 32'h1, 4'h0, P1 | P3 | P4, 32'h0);
    add_step(OP_WR, ADDR_MULTI_FUNC, 32'h0, 4'hF, NO_PADS, 32'h0);
    add_step(OP_WR, ADDR_GPIO_DIR, 32'h0, 4'hF, NO_PADS, 32'h0);
    add_step(OP_CHK, 8'h00, 32'h0, 4'h0, NO_PADS, 32'h0);
  endtask

  // Watchdog sized from the table
  initial begin
    wait (table_ready);
    #((steps.size() * 200 + PWM_TEST_CYC) * 10);
    $display("Watchdog expired before the tests completed");
    $display("Testbench failed");
    $finish;
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] rd;
    int          low_len;
    int          high_len;
    rst_n_i         = 1'b0;
    reg_req         = '0;
    digital_io_in_i = '0;
    uart_txd_i      = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge mclk);
    #1;
    // Idle state under reset
    check_val("reg_rsp_o.ack", 32'h0, 32'(reg_rsp_o.ack));
    check_val("digital_io_out_o", 32'h0, 32'(digital_io_out_o));
    check_val("digital_io_oen_o", 32'h00FF_FFFF, 32'(digital_io_oen_o));
    check_val("gpio_irq_o", 32'h0, 32'(gpio_irq_o));
    check_val("ext_irq_o", 32'h0, 32'(ext_irq_o));
    rst_n_i = 1'b1;
    @(posedge mclk);
    #1;
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    // PWM0 at 2 cycles per us and 4 us per ms with 3 ms high and 2 ms low
    bus_access(1'b1, ADDR_MULTI_FUNC, 32'h0, 4'hF, rd);
    bus_access(1'b1, ADDR_PULSE_1US, 32'h1, 4'hF, rd);
    bus_access(1'b1, ADDR_PWM_BASE, 32'h0002_0003, 4'hF, rd);
    bus_access(1'b1, ADDR_MULTI_FUNC, 32'h0000_0001, 4'hF, rd);
    // First high phase may be partial
    wait_pwm0(1'b0, low_len);
    wait_pwm0(1'b1, low_len);
    wait_pwm0(1'b0, high_len);
    check_val("pwm0 low cycles", 32'd16, 32'(low_len));
    check_val("pwm0 high cycles", 32'd24, 32'(high_len));
    $display("Run finished with %0d checks and %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
pinmux_cfg_pkg.sv
pinmux_pad_pkg.sv
pinmux_reg.sv
gpio_intr.sv
pulse_tick_gen.sv
pwm_gen.sv
pad_in_demux.sv
pad_out_mux.sv
pinmux_top.sv
tb_pinmux.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_pinmux
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
